/* src/rom_pkg.sv */
// shared widths, region offset and bus types for the rom fetch block, imported by every rtl module
package rom_pkg;

    // address widths
    localparam int sdram_aw    = 22;   // sdram word address
    localparam int main_aw     = 15;   // main cpu byte address, 32 kB
    localparam int obj_aw      = 13;   // object word address, 32 kB of 32-bit words

    // object region base, in sdram words
    localparam logic [sdram_aw-1:0] obj_offset = sdram_aw'(16384);

    // pxl_cen pulses from clear release to ready
    localparam int ready_delay = 5;

    // sdram read port as seen from the arbiter
    typedef struct packed {
        logic                re;     // toggles, each edge asks for a read
        logic [sdram_aw-1:0] addr;   // word address, held until next request
    } sdram_bus_t;

    // halfword view of the sdram word
    typedef struct packed {
        logic [15:0] hi;   // upper halfword, unused by the main slot
        logic [15:0] lo;   // lower halfword, holds two code bytes
    } half_pair_t;

    // one sdram word, read whole by the object slot or as halfwords by the main slot
    typedef union packed {
        logic [31:0] word;   // object engine view
        half_pair_t  half;   // main cpu view
    } sdram_word_u;

endpackage

/* src/rom_slot.sv */
// one-entry rom cache slot, flags a miss towards the arbiter and latches the sdram word when selected
`timescale 1ns/1ps

module rom_slot
    import rom_pkg::*;
#(
    parameter int AW        = 15,     // client address width
    parameter int DW        = 8,      // client data width, 8 or 32
    parameter bit BYTE_SWAP = 1'b0    // swap byte order inside the halfword
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cen,        // pixel clock enable
    input  logic [AW-1:0] addr,       // address from the client
    input  logic          we,         // select from the arbiter
    input  sdram_word_u   din,        // word returned by the sdram
    output logic [AW-1:0] addr_req,   // address to be fetched
    output logic          req,        // miss, held until the slot is refilled
    output logic [DW-1:0] dout        // data towards the client
);

    logic          valid;         // slot holds a fetched word
    logic [AW-1:0] cached_addr;   // address of the cached word
    logic          hit;           // current address served from the slot

    assign addr_req = addr;   // the slot always asks for what the client shows
    assign req      = ~hit;   // any miss keeps requesting

    // valid is the only control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (cen && we) begin
            valid <= 1'b1;   // first refill fills the slot
        end
    end

    // tag of the word in the slot
    always_ff @(posedge clk) begin
        if (cen && we) begin
            cached_addr <= addr;   // taken together with din
        end
    end

    generate
        if (DW == 8) begin : g_byte
            logic [15:0] cached_half;   // two code bytes
            logic        hi_sel;        // pick the upper byte

            always_ff @(posedge clk) begin
                if (cen && we) begin
                    cached_half <= din.half.lo;   // upper halfword dropped
                end
            end

            // both bytes of the halfword are in the slot, so bit 0 is not part of the tag
            assign hit    = valid && (cached_addr[AW-1:1] == addr[AW-1:1]);
            assign hi_sel = addr[0] ^ BYTE_SWAP;   // swapped order flips the pick
            assign dout   = hi_sel ? cached_half[15:8] : cached_half[7:0];
        end else begin : g_word
            logic [31:0] cached_word;   // whole object word

            always_ff @(posedge clk) begin
                if (cen && we) begin
                    cached_word <= din.word;
                end
            end

            assign hit  = valid && (cached_addr == addr);   // full address tag
            assign dout = cached_word;
        end
    endgenerate

endmodule

/* src/rom_arbiter.sv */
// sdram read arbiter for the two rom slots, with priority choice, read strobe and ready delay
`timescale 1ns/1ps

module rom_arbiter
    import rom_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,         // pixel clock enable
    input  logic               downloading,     // rom download in progress
    input  logic               loop_rst,        // core held in reset
    input  logic               main_req,        // main slot miss
    input  logic [main_aw-1:0] main_addr_req,   // main cpu byte address
    input  logic               obj_req,         // object slot miss
    input  logic [obj_aw-1:0]  obj_addr_req,    // object word address
    output logic               main_we,         // main slot select
    output logic               obj_we,          // object slot select
    output sdram_bus_t         sdram,           // strobe and word address
    output logic               ready            // roms usable by the core
);

    logic                   clear;        // download or loop reset active
    logic                   re_q;         // read strobe
    logic [sdram_aw-1:0]    addr_q;       // registered word address
    logic [sdram_aw-1:0]    main_word;    // main byte address as sdram word
    logic [sdram_aw-1:0]    obj_word;     // object address inside its region
    logic [ready_delay-2:0] ready_cnt;    // ones shift in, ready is the last stage

    assign clear = downloading || loop_rst;

    // two code bytes per sdram word, so bit 0 goes
    assign main_word = sdram_aw'(main_addr_req[main_aw-1:1]);

    // each object word takes two sdram words in the region
    assign obj_word  = obj_offset + sdram_aw'({obj_addr_req, 1'b0});

    assign sdram.re   = re_q;
    assign sdram.addr = addr_q;

    // strobe only moves on pxl_cen, both edges count as requests
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            re_q <= 1'b0;
        end else if (pxl_cen) begin
            if (clear) begin
                re_q <= 1'b0;   // parked low until the core runs
            end else if (main_req || obj_req) begin
                re_q <= ~re_q;   // one edge per missing pxl_cen
            end
        end
    end

    // address, selects and ready counter
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            addr_q    <= '0;   // cleared on every clk while held
            ready_cnt <= '0;
            ready     <= 1'b0;
            main_we   <= 1'b0;   // no slot captures while clearing
            obj_we    <= 1'b0;
        end else if (pxl_cen) begin
            {ready, ready_cnt} <= {ready_cnt, 1'b1};   // ready after ready_delay pulses

            if (main_req) begin
                addr_q  <= main_word;   // main cpu wins a tie
                main_we <= 1'b1;
                obj_we  <= 1'b0;
            end else if (obj_req) begin
                addr_q  <= obj_word;
                main_we <= 1'b0;
                obj_we  <= 1'b1;
            end else begin
                main_we <= 1'b0;   // both hit, address held
                obj_we  <= 1'b0;
            end
        end
    end

endmodule

/* src/rom_top.sv */
// rom fetch block top, two cache slots sharing one sdram read port through the arbiter
`timescale 1ns/1ps

module rom_top
    import rom_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,       // pixel clock enable
    input  logic               downloading,   // rom download in progress
    input  logic               loop_rst,      // core reset
    input  logic [main_aw-1:0] main_addr,     // main cpu code address, bytes
    input  logic [obj_aw-1:0]  obj_addr,      // object engine address, words
    output logic [7:0]         main_dout,     // code byte
    output logic [31:0]        obj_dout,      // object word
    output logic               ready,         // roms usable
    output sdram_bus_t         sdram,         // sdram read request
    input  sdram_word_u        data_read      // sdram read data
);

    logic               main_req;        // main slot miss
    logic [main_aw-1:0] main_addr_req;   // main fetch address
    logic               main_we;         // main slot select
    logic               obj_req;         // object slot miss
    logic [obj_aw-1:0]  obj_addr_req;    // object fetch address
    logic               obj_we;          // object slot select

    // main cpu code, byte wide with swapped byte order
    rom_slot #(
        .AW        (main_aw),
        .DW        (8),
        .BYTE_SWAP (1'b1)
    ) u_main (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (pxl_cen),
        .addr     (main_addr),
        .we       (main_we),
        .din      (data_read),
        .addr_req (main_addr_req),
        .req      (main_req),
        .dout     (main_dout)
    );

    // object engine, whole words
    rom_slot #(
        .AW        (obj_aw),
        .DW        (32),
        .BYTE_SWAP (1'b0)
    ) u_obj (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (pxl_cen),
        .addr     (obj_addr),
        .we       (obj_we),
        .din      (data_read),
        .addr_req (obj_addr_req),
        .req      (obj_req),
        .dout     (obj_dout)
    );

    rom_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .pxl_cen       (pxl_cen),
        .downloading   (downloading),
        .loop_rst      (loop_rst),
        .main_req      (main_req),
        .main_addr_req (main_addr_req),
        .obj_req       (obj_req),
        .obj_addr_req  (obj_addr_req),
        .main_we       (main_we),
        .obj_we        (obj_we),
        .sdram         (sdram),
        .ready         (ready)
    );

endmodule

/* tests/sdram_model.sv */
// behavioural sdram read port for the testbench, every word is a fixed mix of its own address
`timescale 1ns/1ps

module sdram_model
    import rom_pkg::*;
(
    input  logic        clk,
    input  sdram_bus_t  sdram,       // strobe and word address from the dut
    output sdram_word_u data_read    // word for the registered address
);

    // address times an odd constant, then a fixed pattern on top
    function automatic logic [31:0] word_at(input logic [sdram_aw-1:0] addr);
        return ({10'd0, addr} * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    // one clk of latency, well inside a pxl_cen period
    // the strobe is ignored, the address alone picks the word
    always_ff @(posedge clk) begin
        data_read.word <= word_at(sdram.addr);
    end

endmodule

/* tests/tb_rom_top.sv */
// testbench for the rom fetch block, directed read, priority, hit and clear tests on a model sdram
`timescale 1ns/1ps

module tb_rom_top
    import rom_pkg::*;
();

    logic               clk = 1'b0;
    logic               rst_n;
    logic               pxl_cen = 1'b0;   // one clk in four
    logic [1:0]         cen_div = 2'd0;
    logic               downloading;
    logic               loop_rst;
    logic [main_aw-1:0] main_addr;
    logic [obj_aw-1:0]  obj_addr;
    logic [7:0]         main_dout;
    logic [31:0]        obj_dout;
    logic               ready;
    sdram_bus_t         sdram;
    sdram_word_u        data_read;
    int                 checks = 0;
    int                 errors = 0;
    int                 timeouts = 0;

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        cen_div <= cen_div + 2'd1;
        pxl_cen <= (cen_div == 2'd3);
    end

    rom_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .pxl_cen     (pxl_cen),
        .downloading (downloading),
        .loop_rst    (loop_rst),
        .main_addr   (main_addr),
        .obj_addr    (obj_addr),
        .main_dout   (main_dout),
        .obj_dout    (obj_dout),
        .ready       (ready),
        .sdram       (sdram),
        .data_read   (data_read)
    );

    sdram_model u_sdram (
        .clk       (clk),
        .sdram     (sdram),
        .data_read (data_read)
    );

    // expected sdram contents, same address mix as the model
    function automatic logic [31:0] expected_word(input logic [sdram_aw-1:0] addr);
        return ({10'd0, addr} * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [sdram_aw-1:0] main_word_addr(input logic [main_aw-1:0] a);
        return {8'd0, a[main_aw-1:1]};   // two code bytes per word
    endfunction

    function automatic logic [sdram_aw-1:0] obj_word_addr(input logic [obj_aw-1:0] a);
        return obj_offset + {8'd0, a, 1'b0};   // region base plus twice the index
    endfunction

    function automatic logic [7:0] expected_byte(input logic [main_aw-1:0] a);
        logic [31:0] w;
        w = expected_word(main_word_addr(a));
        return a[0] ? w[7:0] : w[15:8];   // swapped, even byte sits high in lo
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // returns on the negedge after the next pxl_cen edge, outputs settled
    task automatic wait_cen();
        int  n;
        bit  seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 8) begin
            @(posedge clk);
            n++;
            seen = pxl_cen;   // value the dut sampled on this edge
        end
        if (!seen) begin
            timeouts++;
            $display("timeout: no pxl_cen pulse within 8 clk cycles at time %0t", $time);
        end
        @(negedge clk);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < 10) begin
            wait_cen();
            n++;
        end
        if (!ready) begin
            timeouts++;
            $display("timeout: ready did not rise within 10 pxl_cen pulses at time %0t", $time);
        end
    endtask

    task automatic drive_addrs(input logic [main_aw-1:0] m, input logic [obj_aw-1:0] o);
        @(posedge clk);
        main_addr <= m;
        obj_addr  <= o;
    endtask

    task automatic read_main(input logic [main_aw-1:0] m);
        drive_addrs(m, obj_addr);
        repeat (2) wait_cen();   // miss registered, then word captured
        check_value($sformatf("main byte at %h", m), 32'(main_dout), 32'(expected_byte(m)));
        wait_cen();
        check_value($sformatf("main byte at %h held", m), 32'(main_dout),
                    32'(expected_byte(m)));
    endtask

    task automatic read_obj(input logic [obj_aw-1:0] o);
        drive_addrs(main_addr, o);
        repeat (2) wait_cen();
        check_value($sformatf("obj word at %h", o), obj_dout, expected_word(obj_word_addr(o)));
        wait_cen();
        check_value($sformatf("obj word at %h held", o), obj_dout,
                    expected_word(obj_word_addr(o)));
    endtask

    task automatic ready_after_download();
        repeat (3) begin
            wait_cen();
            check_value("ready low while downloading", 32'(ready), 32'd0);
            check_value("strobe low while downloading", 32'(sdram.re), 32'd0);
        end
        @(posedge clk);
        downloading <= 1'b0;
        for (int k = 1; k <= 5; k++) begin
            wait_cen();
            check_value($sformatf("ready after pulse %0d", k), 32'(ready), 32'(k == 5));
        end
        @(posedge clk);
        downloading <= 1'b1;
        @(posedge clk);   // clear acts on this clk, no pxl_cen needed
        @(negedge clk);
        check_value("ready drops with downloading", 32'(ready), 32'd0);
        wait_cen();
        check_value("addr cleared while downloading", 32'(sdram.addr), 32'd0);
        @(posedge clk);
        downloading <= 1'b0;
        wait_ready();
    endtask

    task automatic main_wins_tie();
        logic [main_aw-1:0]  m;
        logic [obj_aw-1:0]   o;
        logic [sdram_aw-1:0] prev;
        logic [sdram_aw-1:0] issued[$];
        logic                re_prev;
        int                  edges;
        do begin
            m = main_aw'($urandom);
        end while (m[main_aw-1:1] == main_addr[main_aw-1:1] || main_word_addr(m) == sdram.addr);
        do begin
            o = obj_aw'($urandom);
        end while (o == obj_addr);
        prev    = sdram.addr;
        re_prev = sdram.re;
        edges   = 0;
        drive_addrs(m, o);
        repeat (6) begin
            wait_cen();
            if (sdram.addr != prev) begin
                issued.push_back(sdram.addr);   // distinct addresses in order
                prev = sdram.addr;
            end
            if (sdram.re != re_prev) begin
                edges++;   // each miss pulse is one edge
                re_prev = sdram.re;
            end
        end
        if (issued.size() < 2) begin
            errors++;
            $display("priority test: only %0d sdram addresses issued where two were due",
                     issued.size());
        end else begin
            check_value("first fetch is main", 32'(issued[0]), 32'(main_word_addr(m)));
            check_value("second fetch is obj", 32'(issued[1]), 32'(obj_word_addr(o)));
        end
        check_value("strobe edges for two misses", 32'(edges), 32'd4);   // two pulses each
        check_value("main byte after tie", 32'(main_dout), 32'(expected_byte(m)));
        check_value("obj word after tie", obj_dout, expected_word(obj_word_addr(o)));
    endtask

    task automatic repeat_addr_hits();
        logic re_before;
        re_before = sdram.re;
        drive_addrs(main_addr, obj_addr);   // same addresses again
        repeat (3) begin
            wait_cen();
            check_value("strobe still on repeat", 32'(sdram.re), 32'(re_before));
        end
        drive_addrs({main_addr[main_aw-1:1], ~main_addr[0]}, obj_addr);   // other byte
        @(negedge clk);
        check_value("other byte of cached word", 32'(main_dout), 32'(expected_byte(main_addr)));
        repeat (3) begin
            wait_cen();
            check_value("strobe still on byte hit", 32'(sdram.re), 32'(re_before));
        end
    endtask

    task automatic loop_rst_recovery();
        logic [main_aw-1:0] m;
        logic [obj_aw-1:0]  o;
        @(posedge clk);
        loop_rst <= 1'b1;
        wait_cen();
        check_value("addr cleared by loop_rst", 32'(sdram.addr), 32'd0);
        check_value("ready cleared by loop_rst", 32'(ready), 32'd0);
        do begin
            m = main_aw'($urandom);
        end while (m[main_aw-1:1] == main_addr[main_aw-1:1]);   // main must miss
        o = obj_aw'($urandom);
        drive_addrs(m, o);   // misses wait for the release
        repeat (2) begin
            wait_cen();
            check_value("addr held at zero", 32'(sdram.addr), 32'd0);
            check_value("ready held low", 32'(ready), 32'd0);
            check_value("strobe held low", 32'(sdram.re), 32'd0);
        end
        @(posedge clk);
        loop_rst <= 1'b0;
        wait_ready();   // both fetches finish inside the delay
        check_value("main byte after loop_rst", 32'(main_dout), 32'(expected_byte(m)));
        check_value("obj word after loop_rst", obj_dout, expected_word(obj_word_addr(o)));
        read_main(main_aw'($urandom));
        read_obj(obj_aw'($urandom));
    endtask

    initial begin
        void'($urandom(60));
        rst_n       <= 1'b0;
        downloading <= 1'b1;   // core starts during rom download
        loop_rst    <= 1'b0;
        main_addr   <= '0;
        obj_addr    <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        ready_after_download();
        repeat (4) read_main(main_aw'($urandom));
        repeat (4) read_obj(obj_aw'($urandom));
        main_wins_tie();
        repeat_addr_hits();
        loop_rst_recovery();

        $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* build.f */
src/rom_pkg.sv
src/rom_slot.sv
src/rom_arbiter.sv
src/rom_top.sv
tests/sdram_model.sv
tests/tb_rom_top.sv

/* run.sh */
#!/bin/sh
# build the rom fetch testbench with verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_rom_top -f build.f -o sim_rom_top
./obj_dir/sim_rom_top > sim.log 2>&1
cat sim.log
if grep -qx "sim passed" sim.log; then
    echo "run.sh: simulation reported success"
else
    echo "run.sh: simulation reported failure"
    exit 1
fi
